//--- Makefile
VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- cache/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_top
	import cache_pkg::*;
(
	input  logic                     clk,
	input  logic                     reset,
	input  logic [`CACHE_ADDR_W-1:0] address,
	input  logic                     read_signal,
	input  logic                     write_signal,
	input  cache_line_t              write_data,
	output logic                     hit,
	output logic                     read_hit,
	output logic                     write_hit,
	output logic                     halt_hit,
	output logic [`CACHE_BYTE_W-1:0] read_data
);

	logic [`CACHE_WAYS-1:0]  way_match;
	logic [`CACHE_WAYS-1:0]  way_halt_match;
	logic [`CACHE_WAYS-1:0]  way_valid;
	logic [`CACHE_WAYS-1:0]  way_write;
	cache_line_t             way_lines [`CACHE_WAYS];

	logic [`CACHE_WAY_W-1:0] hit_way;
	logic [`CACHE_WAY_W-1:0] victim_way;
	logic [`CACHE_WAY_W-1:0] write_way;
	logic                    access;
	logic                    store;

	assign access = read_signal || write_signal;

	// A read hit leaves the line alone, everything else stores one
	assign store     = write_hit || (access && !hit);
	assign write_way = hit ? hit_way : victim_way;

	always_comb
	begin
		way_write = '0;
		if (store)
		begin
			way_write[write_way] = 1'b1;
		end
	end

	generate
		for (genvar w = 0; w < `CACHE_WAYS; w++)
		begin : g_way
			cache_way way_inst
			(
				.clk          (clk),
				.reset        (reset),
				.address      (address),
				.write_enable (way_write[w]),
				.write_data   (write_data),
				.match        (way_match[w]),
				.halt_match   (way_halt_match[w]),
				.valid        (way_valid[w]),
				.line         (way_lines[w])
			);
		end
	endgenerate

	hit_select hit_select_inst
	(
		.match        (way_match),
		.halt_match   (way_halt_match),
		.lines        (way_lines),
		.offset       (address[`CACHE_OFFSET_W-1:0]),
		.read_signal  (read_signal),
		.write_signal (write_signal),
		.hit          (hit),
		.read_hit     (read_hit),
		.write_hit    (write_hit),
		.halt_hit     (halt_hit),
		.hit_way      (hit_way),
		.read_data    (read_data)
	);

	// Victim choice looks at the valid bits of the addressed set only
	lru_replace lru_replace_inst
	(
		.clk        (clk),
		.reset      (reset),
		.index      (address[`CACHE_INDEX_LSB +: `CACHE_INDEX_W]),
		.access     (access),
		.hit        (hit),
		.hit_way    (hit_way),
		.valid      (way_valid),
		.victim_way (victim_way)
	);

endmodule

`default_nettype wire

//--- cache/cache_way.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_way
	import cache_pkg::*;
(
	input  logic                     clk,
	input  logic                     reset,
	input  logic [`CACHE_ADDR_W-1:0] address,
	input  logic                     write_enable,
	input  cache_line_t              write_data,
	output logic                     match,
	output logic                     halt_match,
	output logic                     valid,
	output cache_line_t              line
);

	logic [`CACHE_INDEX_W-1:0] index;
	logic [`CACHE_TAG_W-1:0]   addr_tag;
	logic [`CACHE_HALT_W-1:0]  addr_halt;

	// One entry per set
	logic [`CACHE_SETS-1:0]    valid_bits;
	logic [`CACHE_TAG_W-1:0]   tag_mem [`CACHE_SETS];
	logic [`CACHE_HALT_W-1:0]  halt_mem [`CACHE_SETS];
	cache_line_t               line_mem [`CACHE_SETS];

	logic                      tag_equal;

	assign index     = address[`CACHE_INDEX_LSB +: `CACHE_INDEX_W];
	assign addr_tag  = address[`CACHE_TAG_LSB +: `CACHE_TAG_W];
	assign addr_halt = address[`CACHE_HALT_LSB +: `CACHE_HALT_W];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			valid_bits <= '0;
		end
		else if (write_enable)
		begin
			valid_bits[index] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (write_enable)
		begin
			tag_mem[index]  <= addr_tag;
			halt_mem[index] <= addr_halt;
			line_mem[index] <= write_data;
		end
	end

	assign valid = valid_bits[index];

	// The short halt tag is checked first
	// A way whose halt tag differs never enables its full tag compare
	assign halt_match = valid && (halt_mem[index] == addr_halt);

	always_comb
	begin
		tag_equal = 1'b0;
		if (halt_match)
		begin
			tag_equal = (tag_mem[index] == addr_tag);
		end
	end

	assign match = halt_match && tag_equal;
	assign line  = line_mem[index];

endmodule

`default_nettype wire

//--- cache/hit_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module hit_select
	import cache_pkg::*;
(
	input  logic [`CACHE_WAYS-1:0]     match,
	input  logic [`CACHE_WAYS-1:0]     halt_match,
	input  cache_line_t                lines [`CACHE_WAYS],
	input  logic [`CACHE_OFFSET_W-1:0] offset,
	input  logic                       read_signal,
	input  logic                       write_signal,
	output logic                       hit,
	output logic                       read_hit,
	output logic                       write_hit,
	output logic                       halt_hit,
	output logic [`CACHE_WAY_W-1:0]    hit_way,
	output logic [`CACHE_BYTE_W-1:0]   read_data
);

	cache_line_t hit_line;
	logic        way_found;

	assign hit       = |match;
	assign halt_hit  = |halt_match;
	assign read_hit  = hit && read_signal;
	assign write_hit = hit && write_signal;

	// Only one way should match, the lowest one wins if several do
	always_comb
	begin
		way_found = 1'b0;
		hit_way   = '0;
		for (int w = 0; w < `CACHE_WAYS; w++)
		begin
			if (!way_found && match[w])
			begin
				way_found = 1'b1;
				hit_way   = `CACHE_WAY_W'(w);
			end
		end
	end

	assign hit_line = lines[hit_way];

	always_comb
	begin
		read_data = '0;
		if (read_hit)
		begin
			read_data = hit_line.bytes[offset];
		end
	end

endmodule

`default_nettype wire

//--- cache/lru_replace.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module lru_replace
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic [`CACHE_INDEX_W-1:0] index,
	input  logic                      access,
	input  logic                      hit,
	input  logic [`CACHE_WAY_W-1:0]   hit_way,
	input  logic [`CACHE_WAYS-1:0]    valid,
	output logic [`CACHE_WAY_W-1:0]   victim_way
);

	// Row w of a set's matrix holds the ways that w was used more recently than
	logic [`CACHE_WAYS-1:0][`CACHE_WAYS-1:0] lru_mat [`CACHE_SETS];
	logic [`CACHE_WAYS-1:0][`CACHE_WAYS-1:0] set_mat;
	logic [`CACHE_WAYS-1:0][`CACHE_WAYS-1:0] set_mat_next;

	logic [`CACHE_WAY_W-1:0] touched_way;
	logic [`CACHE_WAY_W-1:0] invalid_way;
	logic [`CACHE_WAY_W-1:0] lru_way;
	logic                    invalid_found;
	logic                    lru_found;

	assign set_mat = lru_mat[index];

	// A hit refreshes the hit way, a miss the way that receives the fill
	assign touched_way = hit ? hit_way : victim_way;

	always_comb
	begin
		set_mat_next = set_mat;
		set_mat_next[touched_way] = '1;
		for (int r = 0; r < `CACHE_WAYS; r++)
		begin
			set_mat_next[r][touched_way] = 1'b0;
		end
	end

	always_comb
	begin
		invalid_found = 1'b0;
		invalid_way   = '0;
		for (int w = 0; w < `CACHE_WAYS; w++)
		begin
			if (!invalid_found && !valid[w])
			begin
				invalid_found = 1'b1;
				invalid_way   = `CACHE_WAY_W'(w);
			end
		end
	end

	// The least recently used way has an empty row
	always_comb
	begin
		lru_found = 1'b0;
		lru_way   = '0;
		for (int w = 0; w < `CACHE_WAYS; w++)
		begin
			if (!lru_found && (set_mat[w] == '0))
			begin
				lru_found = 1'b1;
				lru_way   = `CACHE_WAY_W'(w);
			end
		end
	end

	assign victim_way = invalid_found ? invalid_way : lru_way;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int s = 0; s < `CACHE_SETS; s++)
			begin
				lru_mat[s] <= '0;
			end
		end
		else if (access)
		begin
			lru_mat[index] <= set_mat_next;
		end
	end

endmodule

`default_nettype wire

//--- common/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Address fields from high to low are tag, halt tag, set index and byte offset
`define CACHE_ADDR_W     32
`define CACHE_TAG_W      22
`define CACHE_HALT_W     4
`define CACHE_INDEX_W    3
`define CACHE_OFFSET_W   3

// Low bit position of each address field
`define CACHE_TAG_LSB    10
`define CACHE_HALT_LSB   6
`define CACHE_INDEX_LSB  3

// Organisation of the cache
`define CACHE_WAYS       8
`define CACHE_SETS       8
`define CACHE_WAY_W      3

// One line is eight bytes
`define CACHE_LINE_W     64
`define CACHE_BYTE_W     8

`endif

//--- common/cache_pkg.sv
`default_nettype none

`include "cache_macros.svh"

package cache_pkg;

	// A cache line is stored and filled as one word
	// The read path picks a single byte out of it through the byte view
	typedef union packed {
		logic [`CACHE_LINE_W-1:0] word;
		logic [`CACHE_LINE_W/`CACHE_BYTE_W-1:0][`CACHE_BYTE_W-1:0] bytes;
	} cache_line_t;

endpackage

`default_nettype wire

//--- filelist.f
+incdir+common
common/cache_pkg.sv
cache/cache_way.sv
cache/lru_replace.sv
cache/hit_select.sv
cache/cache_top.sv
sim/cache_clock.sv
sim/cache_asserts.sv
sim/cache_tb.sv

//--- sim/cache_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module cache_asserts
(
	input logic clk,
	input logic reset,
	input logic read_signal,
	input logic write_signal,
	input logic hit,
	input logic read_hit,
	input logic write_hit,
	input logic halt_hit
);

	// An access is either a read or a write, never both
	single_access: assert property (@(posedge clk) !(read_signal && write_signal))
		else $error("read_signal and write_signal are high in the same cycle");

	read_hit_is_hit: assert property (@(posedge clk) read_hit |-> hit)
		else $error("read_hit is high while hit is low");

	// The valid bits are cleared by the first reset edge
	flags_low_in_reset: assert property (@(posedge clk)
		(reset && $past(reset)) |-> !(hit || read_hit || write_hit || halt_hit))
		else $error("a hit flag is high during reset");

endmodule

`default_nettype wire

//--- sim/cache_clock.sv
`timescale 1ns/1ps
`default_nettype none

module cache_clock
#(
	parameter int PERIOD_NS = 40
)
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
	end

	always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- sim/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_tb
	import cache_pkg::*;
();

	logic                       clk;
	logic                       reset;
	logic [`CACHE_ADDR_W-1:0]   address;
	logic                       read_signal;
	logic                       write_signal;
	cache_line_t                write_data;
	logic                       hit;
	logic                       read_hit;
	logic                       write_hit;
	logic                       halt_hit;
	logic [`CACHE_BYTE_W-1:0]   read_data;

	// Stimulus columns and the expected columns filled in by the model
	logic [`CACHE_ADDR_W-1:0]   tbl_addr [$];
	logic                       tbl_write [$];
	cache_line_t                tbl_data [$];
	logic                       exp_hit [$];
	logic                       exp_halt [$];
	logic [`CACHE_BYTE_W-1:0]   exp_data [$];

	// Model state, the key is the tag and halt tag together
	logic [`CACHE_ADDR_W-1:`CACHE_HALT_LSB] m_key [`CACHE_SETS][`CACHE_WAYS];
	logic                       m_valid [`CACHE_SETS][`CACHE_WAYS];
	cache_line_t                m_line [`CACHE_SETS][`CACHE_WAYS];
	int                         m_stamp [`CACHE_SETS][`CACHE_WAYS];

	logic [31:0]                lfsr_state = 32'd95277;
	int                         checks;
	int                         errors;
	int                         cycles;
	int                         cycle_limit;

	cache_clock #(.PERIOD_NS(40)) cache_clock_inst (.clk(clk));

	cache_top cache_top_inst
	(
		.clk          (clk),
		.reset        (reset),
		.address      (address),
		.read_signal  (read_signal),
		.write_signal (write_signal),
		.write_data   (write_data),
		.hit          (hit),
		.read_hit     (read_hit),
		.write_hit    (write_hit),
		.halt_hit     (halt_hit),
		.read_data    (read_data)
	);

	bind cache_top cache_asserts cache_asserts_inst
	(
		.clk          (clk),
		.reset        (reset),
		.read_signal  (read_signal),
		.write_signal (write_signal),
		.hit          (hit),
		.read_hit     (read_hit),
		.write_hit    (write_hit),
		.halt_hit     (halt_hit)
	);

	// Galois form of the 32-bit polynomial with taps 32, 30, 26 and 25
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'hA300_0000) : (state >> 1);
	endfunction

	function automatic cache_line_t random_line();
		cache_line_t value;
		for (int b = 0; b < `CACHE_LINE_W; b++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			value.word[b] = lfsr_state[0];
		end
		return value;
	endfunction

	function automatic logic [`CACHE_ADDR_W-1:0] make_addr(input logic [21:0] tag,
		input logic [3:0] halt, input logic [2:0] set, input logic [2:0] offset);
		return {tag, halt, set, offset};
	endfunction

	task automatic add_row(input logic [`CACHE_ADDR_W-1:0] addr, input logic write);
		tbl_addr.push_back(addr);
		tbl_write.push_back(write);
		tbl_data.push_back(random_line());
	endtask

	task automatic build_table();
		// Empty cache, every access misses
		add_row(make_addr(22'h00011, 4'h2, 3'd0, 3'd0), 1'b0);
		add_row(make_addr(22'h00012, 4'h3, 3'd2, 3'd4), 1'b1);
		// Read miss fills set 1, then every offset is read back
		for (int o = 0; o < 9; o++)
			add_row(make_addr(22'h2a5f0, 4'h5, 3'd1, 3'(o)), 1'b0);
		// Write hit replaces the line
		add_row(make_addr(22'h2a5f0, 4'h5, 3'd1, 3'd2), 1'b1);
		for (int o = 0; o < 8; o++)
			add_row(make_addr(22'h2a5f0, 4'h5, 3'd1, 3'(o)), 1'b0);
		// Same tag with other halt tags in the same set
		add_row(make_addr(22'h2a5f0, 4'h9, 3'd1, 3'd6), 1'b0);
		add_row(make_addr(22'h2a5f0, 4'h9, 3'd1, 3'd6), 1'b0);
		add_row(make_addr(22'h2a5f0, 4'hc, 3'd1, 3'd1), 1'b0);
		// Fill all ways of set 5, re-touch a few, then force an eviction
		for (int k = 0; k < 8; k++)
			add_row(make_addr(22'h00100 + 22'(k), 4'h7, 3'd5, 3'(k)), 1'b0);
		add_row(make_addr(22'h00103, 4'h7, 3'd5, 3'd1), 1'b0);
		add_row(make_addr(22'h00100, 4'h7, 3'd5, 3'd2), 1'b1);
		add_row(make_addr(22'h00106, 4'h7, 3'd5, 3'd3), 1'b0);
		add_row(make_addr(22'h00101, 4'h7, 3'd5, 3'd4), 1'b0);
		add_row(make_addr(22'h001ff, 4'h7, 3'd5, 3'd5), 1'b0);
		for (int k = 0; k < 8; k++)
			add_row(make_addr(22'h00100 + 22'(k), 4'h7, 3'd5, 3'(7 - k)), 1'b0);
		add_row(make_addr(22'h001ff, 4'h7, 3'd5, 3'd0), 1'b0);
	endtask

	// Runs the table through the cache rules and records what the DUT must answer
	task automatic run_model();
		logic [`CACHE_ADDR_W-1:0] addr;
		logic [2:0]               s;
		logic [2:0]               way;
		logic                     found;
		logic                     halt;
		logic                     free_found;
		int                       byte_lsb;
		for (int i = 0; i < tbl_addr.size(); i++)
		begin
			addr  = tbl_addr[i];
			s     = addr[`CACHE_INDEX_LSB +: `CACHE_INDEX_W];
			found = 1'b0;
			halt  = 1'b0;
			way   = '0;
			for (int w = 0; w < `CACHE_WAYS; w++)
			begin
				if (m_valid[s][w] && (m_key[s][w][`CACHE_HALT_LSB +: `CACHE_HALT_W] ==
					addr[`CACHE_HALT_LSB +: `CACHE_HALT_W]))
					halt = 1'b1;
				if (!found && m_valid[s][w] && (m_key[s][w] == addr[31:`CACHE_HALT_LSB]))
				begin
					found = 1'b1;
					way   = 3'(w);
				end
			end
			// Byte n of a line sits in bits 8n+7 down to 8n
			byte_lsb = addr[`CACHE_OFFSET_W-1:0] * `CACHE_BYTE_W;
			exp_hit.push_back(found);
			exp_halt.push_back(halt);
			exp_data.push_back((found && !tbl_write[i]) ?
				m_line[s][way].word[byte_lsb +: `CACHE_BYTE_W] : '0);
			if (!found)
			begin
				free_found = 1'b0;
				for (int w = 0; w < `CACHE_WAYS; w++)
				begin
					if (!free_found && !m_valid[s][w])
					begin
						free_found = 1'b1;
						way        = 3'(w);
					end
				end
				if (!free_found)
				begin
					way = '0;
					for (int w = 1; w < `CACHE_WAYS; w++)
						if (m_stamp[s][w] < m_stamp[s][way])
							way = 3'(w);
				end
			end
			if (!found || tbl_write[i])
			begin
				m_valid[s][way] = 1'b1;
				m_key[s][way]   = addr[31:`CACHE_HALT_LSB];
				m_line[s][way]  = tbl_data[i];
			end
			m_stamp[s][way] = i + 1;
		end
	endtask

	task automatic check_flag(input int row, input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] row %0d %s got %h expected %h", row, name, got, exp);
		end
	endtask

	task automatic check_read_data(input int row, input logic [`CACHE_BYTE_W-1:0] got,
		input logic [`CACHE_BYTE_W-1:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] row %0d read_data got %h expected %h", row, got, exp);
		end
	endtask

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit)
		begin
			$display("Timeout, the table did not finish within %0d cycles", cycle_limit);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	initial
	begin
		for (int s = 0; s < `CACHE_SETS; s++)
			for (int w = 0; w < `CACHE_WAYS; w++)
				m_valid[s][w] = 1'b0;
		build_table();
		run_model();
		cycle_limit = 8 + tbl_addr.size() + 20;

		reset        <= 1'b1;
		address      <= '0;
		read_signal  <= 1'b0;
		write_signal <= 1'b0;
		write_data   <= '0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;

		for (int i = 0; i < tbl_addr.size(); i++)
		begin
			@(posedge clk);
			address      <= tbl_addr[i];
			read_signal  <= !tbl_write[i];
			write_signal <= tbl_write[i];
			write_data   <= tbl_data[i];
			// Outputs are combinational and have settled by the falling edge
			@(negedge clk);
			check_flag(i, "hit", hit, exp_hit[i]);
			check_flag(i, "read_hit", read_hit, exp_hit[i] && !tbl_write[i]);
			check_flag(i, "write_hit", write_hit, exp_hit[i] && tbl_write[i]);
			check_flag(i, "halt_hit", halt_hit, exp_halt[i]);
			check_read_data(i, read_data, exp_data[i]);
		end
		@(posedge clk);
		read_signal  <= 1'b0;
		write_signal <= 1'b0;
		@(posedge clk);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire
